//--- Bender.yml
package:
  name: mipsCpu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mipsCpuPkg.sv
      - rtl/registerFile.sv
      - rtl/alu.sv
      - rtl/controlUnit.sv
      - rtl/mipsCpuBus.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/avalonMemory.sv
      - test/mipsCpuTb.sv

//--- mipsCpu.f
+incdir+rtl
rtl/mipsCpuPkg.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/controlUnit.sv
rtl/mipsCpuBus.sv
test/avalonMemory.sv
test/mipsCpuTb.sv

//--- rtl/alu.sv
// --------------------
// Shifts use the instruction shamt only; LUI takes bits 15:0 of operandB
// --------------------
module alu
    import mipsCpuPkg::*;
(
    input  aluOp_t aluOp,
    input  word_t  operandA,
    input  word_t  operandB,
    input  shamt_t shamt,
    output word_t  result,
    output logic   rsEqualRt
);

    always_comb begin
        case (aluOp)
            // Wrapping arithmetic, no overflow trap
            ALU_ADD: begin
                result = operandA + operandB;
            end
            ALU_SUB: begin
                result = operandA - operandB;
            end

            // Bitwise logic
            ALU_AND: begin
                result = operandA & operandB;
            end
            ALU_OR: begin
                result = operandA | operandB;
            end
            ALU_XOR: begin
                result = operandA ^ operandB;
            end

            // Compares give 0 or 1
            ALU_SLT: begin
                result = word_t'($signed(operandA) < $signed(operandB));
            end
            ALU_SLTU: begin
                result = word_t'(operandA < operandB);
            end

            // Shifts act on the rt side
            ALU_SLL: begin
                result = operandB << shamt;
            end
            ALU_SRL: begin
                // Zero fill from the top
                result = operandB >> shamt;
            end
            ALU_SRA: begin
                // Sign bit copied into the vacated bits
                result = word_t'($signed(operandB) >>> shamt);
            end

            // Immediate into upper half
            ALU_LUI: begin
                result = {operandB[15:0], 16'h0000};
            end

            default: begin
                result = '0;
            end
        endcase
    end

    // Branch compare on the raw register values
    assign rsEqualRt = (operandA == operandB);

endmodule

//--- rtl/controlUnit.sv
// --------------------
// No delay slots; word accesses only, so byteenable is fixed at 4'b1111
// --------------------
`include "mipsCpu_macros.svh"

module controlUnit
    import mipsCpuPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       waitrequest,
    input  word_t      readdata,
    input  word_t      rsData,
    input  word_t      rtData,
    input  word_t      aluResult,
    input  logic       rsEqualRt,
    output logic       active,
    output logic       read,
    output logic       write,
    output word_t      address,
    output word_t      writedata,
    output logic [3:0] byteenable,
    output regAddr_t   rsAddr,
    output regAddr_t   rtAddr,
    output regAddr_t   writeAddr,
    output logic       writeEnable,
    output word_t      writeData,
    output aluOp_t     aluOp,
    output word_t      operandB,
    output shamt_t     shamt
);

    cpuState_t state;
    cpuState_t stateNext;
    word_t     pc;
    word_t     pcNext;
    word_t     pcPlus4;
    word_t     pcExec;
    word_t     instr;

    // Decoded fields
    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rd;
    imm16_t   imm;
    word_t    immSigned;
    word_t    immZero;
    word_t    branchTarget;
    word_t    jumpTarget;

    // Decode flags
    logic aluWrite;
    logic writeRd;
    logic isLoad;
    logic isStore;

    // Field split of the held instruction
    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign imm    = instr[15:0];

    assign immSigned = {{16{imm[15]}}, imm};
    assign immZero   = {16'h0000, imm};

    // Targets relative to the next sequential instruction
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {immSigned[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};

    // Instruction decode, unknown codes fall through as no-ops
    always_comb begin
        aluOp    = ALU_ADD;
        operandB = rtData;
        aluWrite = 1'b0;
        writeRd  = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        pcExec   = pcPlus4;
        case (opcode)
            OP_RTYPE: begin
                writeRd  = 1'b1;
                aluWrite = 1'b1;
                case (funct)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    FN_SRA:  aluOp = ALU_SRA;
                    FN_JR: begin
                        aluWrite = 1'b0;
                        pcExec   = rsData;
                    end
                    default: aluWrite = 1'b0;
                endcase
            end
            // Sign-extended immediates
            OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                aluWrite = 1'b1;
                operandB = immSigned;
                if (opcode == OP_SLTI) begin
                    aluOp = ALU_SLT;
                end else if (opcode == OP_SLTIU) begin
                    aluOp = ALU_SLTU;
                end
            end
            // Zero-extended immediates
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                aluWrite = 1'b1;
                operandB = immZero;
                case (opcode)
                    OP_ANDI: aluOp = ALU_AND;
                    OP_ORI:  aluOp = ALU_OR;
                    OP_XORI: aluOp = ALU_XOR;
                    default: aluOp = ALU_LUI;
                endcase
            end
            OP_BEQ: pcExec = rsEqualRt ? branchTarget : pcPlus4;
            OP_BNE: pcExec = rsEqualRt ? pcPlus4 : branchTarget;
            OP_J:   pcExec = jumpTarget;
            // Effective address is rs plus offset
            OP_LW: begin
                operandB = immSigned;
                isLoad   = 1'b1;
            end
            OP_SW: begin
                operandB = immSigned;
                isStore  = 1'b1;
            end
            default: aluWrite = 1'b0;
        endcase
    end

    // Next state and PC
    always_comb begin
        stateNext = state;
        pcNext    = pc;
        case (state)
            HALT: begin
                if (!waitrequest) begin
                    stateNext = FETCH;
                end
            end
            FETCH: begin
                if (!waitrequest) begin
                    stateNext = EXEC;
                end
            end
            EXEC: begin
                if (isLoad || isStore) begin
                    stateNext = MEM;
                end else begin
                    pcNext    = pcExec;
                    stateNext = FETCH;
                end
            end
            default: begin
                // MEM completes on the first cycle without wait
                if (!waitrequest) begin
                    pcNext    = pcPlus4;
                    stateNext = FETCH;
                end
            end
        endcase
        // Fetch of the halt address stops the core instead
        if ((stateNext == FETCH) && (state != FETCH) && (pcNext == `HALT_ADDRESS)) begin
            stateNext = HALT;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= HALT;
            pc     <= `RESET_VECTOR;
            active <= 1'b0;
        end else begin
            state  <= stateNext;
            pc     <= pcNext;
            active <= (stateNext != HALT);
        end
    end

    // Instruction register, loaded on fetch completion
    always_ff @(posedge clk) begin
        if ((state == FETCH) && !waitrequest) begin
            instr <= readdata;
        end
    end

    // Bus side, held steady by the state while waitrequest is high
    assign read       = (state == FETCH) || ((state == MEM) && isLoad);
    assign write      = (state == MEM) && isStore;
    assign address    = (state == MEM) ? aluResult : pc;
    assign writedata  = rtData;
    assign byteenable = 4'b1111;

    // Register write back from EXEC or a finished load
    assign writeEnable = ((state == EXEC) && aluWrite)
                       || ((state == MEM) && isLoad && !waitrequest);
    assign writeAddr   = writeRd ? rd : rtAddr;
    assign writeData   = (state == MEM) ? readdata : aluResult;

    busExclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write));

    // Stalled transfer keeps its request and address
    addressHeld: assert property (@(posedge clk) disable iff (reset)
        ((read || write) && waitrequest) |=> ((read || write) && $stable(address)));

endmodule

//--- rtl/mipsCpuBus.sv
// --------------------
// One Avalon-MM master port serves both fetch and data access
// --------------------
module mipsCpuBus
    import mipsCpuPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output word_t      register_v0,
    output word_t      address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata
);

    // Register file ports
    regAddr_t rsAddr;
    regAddr_t rtAddr;
    regAddr_t writeAddr;
    logic     writeEnable;
    word_t    writeData;
    word_t    rsData;
    word_t    rtData;

    // ALU ports
    aluOp_t aluOp;
    word_t  operandB;
    shamt_t shamt;
    word_t  aluResult;
    logic   rsEqualRt;

    // Sequencing, decode and bus master
    controlUnit control0 (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .rsData      (rsData),
        .rtData      (rtData),
        .aluResult   (aluResult),
        .rsEqualRt   (rsEqualRt),
        .active      (active),
        .read        (read),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .rsAddr      (rsAddr),
        .rtAddr      (rtAddr),
        .writeAddr   (writeAddr),
        .writeEnable (writeEnable),
        .writeData   (writeData),
        .aluOp       (aluOp),
        .operandB    (operandB),
        .shamt       (shamt)
    );

    // Operand A is always rs
    alu alu0 (
        .aluOp     (aluOp),
        .operandA  (rsData),
        .operandB  (operandB),
        .shamt     (shamt),
        .result    (aluResult),
        .rsEqualRt (rsEqualRt)
    );

    registerFile regFile0 (
        .clk         (clk),
        .reset       (reset),
        .rsAddr      (rsAddr),
        .rtAddr      (rtAddr),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeData   (writeData),
        .rsData      (rsData),
        .rtData      (rtData),
        .v0          (register_v0)
    );

endmodule

//--- rtl/mipsCpuPkg.sv
// --------------------
// Only the kept MIPS-I subset is listed in the enums
// --------------------
`include "mipsCpu_macros.svh"

package mipsCpuPkg;

    // Data words and byte addresses
    typedef logic [`DATA_WIDTH-1:0] word_t;

    // Instruction fields
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;
    typedef logic [4:0] shamt_t;
    typedef logic [15:0] imm16_t;

    // Primary opcodes, R-type uses the funct field
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } aluOp_t;

    // Core sequencing states
    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2,
        HALT  = 2'd3
    } cpuState_t;

endpackage

//--- rtl/mipsCpu_macros.svh
// --------------------
// Widths assume a 32-bit MIPS-I core, so word-only memory access
// --------------------
`ifndef MIPS_CPU_MACROS_SVH
`define MIPS_CPU_MACROS_SVH

// Data word and address width
`define DATA_WIDTH 32

// Register index width
`define REG_ADDR_WIDTH 5

// General purpose register count
`define NUM_REGS 32

// First fetch after reset
`define RESET_VECTOR 32'hBFC00000

// Fetch from here stops the core
`define HALT_ADDRESS 32'h00000000

`endif

//--- rtl/registerFile.sv
// --------------------
// Asynchronous reads, one write port; writes to $zero are dropped
// --------------------
`include "mipsCpu_macros.svh"

module registerFile
    import mipsCpuPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  regAddr_t rsAddr,
    input  regAddr_t rtAddr,
    input  logic     writeEnable,
    input  regAddr_t writeAddr,
    input  word_t    writeData,
    output word_t    rsData,
    output word_t    rtData,
    output word_t    v0
);

    // General purpose registers
    word_t regs [`NUM_REGS];

    // Single write port, $zero never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Read ports, new values seen after the write edge
    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

    // $v0 tap for the top level
    assign v0 = regs[2];

    // $zero stays zero over any sequence of writes
    zeroRegRead: assert property (@(posedge clk) disable iff (reset)
        (rsAddr == '0) |-> (rsData == '0));

endmodule

//--- test/avalonMemory.sv
// --------------------
// 256 words indexed by address bits 9:2, so the space wraps every 1 KiB
// --------------------
module avalonMemory
    import mipsCpuPkg::*;
(
    input  logic       clk,
    input  logic       waitEnable,
    input  word_t      address,
    input  logic       read,
    input  logic       write,
    input  word_t      writedata,
    input  logic [3:0] byteenable,
    output logic       waitrequest,
    output word_t      readdata
);

    // Storage, loaded and inspected by the testbench
    word_t words [256];

    // Seed for the wait-state draw
    integer seed;

    initial begin
        seed = 32'h8208;
        waitrequest = 1'b0;
    end

    // Wait states change on the falling edge, stable at the sampling edge
    always @(negedge clk) begin
        if (waitEnable) begin
            waitrequest <= (($random(seed) & 32'd1) != 0);
        end else begin
            waitrequest <= 1'b0;
        end
    end

    // Read data valid in the same cycle as the address
    assign readdata = read ? words[address[9:2]] : '0;

    // Write lands on the cycle without wait
    always @(posedge clk) begin
        if (write && !waitrequest) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteenable[lane]) begin
                    words[address[9:2]][lane*8 +: 8] <= writedata[lane*8 +: 8];
                end
            end
        end
    end

endmodule

//--- test/mipsCpuTb.sv
// --------------------
// Programs start at the reset vector, which is word 0 of the memory
// Each program must end with JR through a zero register
// --------------------
`include "mipsCpu_macros.svh"

module mipsCpuTb
    import mipsCpuPkg::*;
();

    localparam int numTests = 4;
    localparam int maxInstr = 12;
    // Word index of byte address 0x300
    localparam int dataIndex = 192;
    // Fill value of the data word when nothing stores to it
    localparam word_t untouchedData = 32'hF0C05AC0;

    localparam regAddr_t rZero = 5'd0;
    localparam regAddr_t rV0 = 5'd2;
    localparam regAddr_t rT0 = 5'd8;
    localparam regAddr_t rT1 = 5'd9;
    localparam regAddr_t rT2 = 5'd10;
    localparam regAddr_t rT3 = 5'd11;

    logic       clk;
    logic       reset;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       write;
    logic       read;
    logic       waitrequest;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata;
    logic       waitEnable;

    // Test table
    string testName [numTests];
    word_t code [numTests][maxInstr];
    int    codeLen [numTests];
    word_t expectV0 [numTests];
    word_t expectMem [numTests];

    mipsCpuBus dut0 (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    avalonMemory mem0 (
        .clk         (clk),
        .waitEnable  (waitEnable),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // MIPS-I instruction formats
    function automatic word_t encodeR(funct_t fn, regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                      shamt_t sa);
        return {6'd0, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t encodeI(opcode_t op, regAddr_t rs, regAddr_t rt, imm16_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encodeJ(word_t target);
        return {OP_J, target[27:2]};
    endfunction

    // Every index bit shows up in the fill
    function automatic word_t fillPattern(logic [7:0] index);
        return {8'hF0, index, 8'h5A, index};
    endfunction

    function automatic word_t expectedWord(int t, int i);
        if (i < codeLen[t]) begin
            return code[t][i];
        end else if (i == dataIndex) begin
            return expectMem[t];
        end
        return fillPattern(i[7:0]);
    endfunction

    task automatic failRun(string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkWord(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkBit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch: %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic newTest(int t, string name, word_t v0, word_t memWord);
        testName[t] = name;
        codeLen[t] = 0;
        expectV0[t] = v0;
        expectMem[t] = memWord;
    endtask

    task automatic addInstr(int t, word_t instr);
        code[t][codeLen[t]] = instr;
        codeLen[t]++;
    endtask

    task automatic buildTable();
        // Register and immediate ALU ops chained into v0
        newTest(0, "aluOps", 32'hFFFFEDE1, untouchedData);
        addInstr(0, encodeI(OP_ORI, rZero, rT0, 16'h1234));
        addInstr(0, encodeI(OP_ADDIU, rZero, rT1, 16'hFFFB));
        addInstr(0, encodeR(FN_ADDU, rT0, rT1, rT2, 0));
        addInstr(0, encodeR(FN_SUBU, rT2, rT1, rT3, 0));
        addInstr(0, encodeR(FN_AND, rT3, rT2, rV0, 0));
        addInstr(0, encodeR(FN_XOR, rV0, rT1, rV0, 0));
        addInstr(0, encodeR(FN_SLT, rT1, rZero, rT0, 0));
        addInstr(0, encodeR(FN_SLTU, rT2, rT1, rT3, 0));
        addInstr(0, encodeR(FN_ADDU, rT0, rT3, rT0, 0));
        addInstr(0, encodeR(FN_ADDU, rV0, rT0, rV0, 0));
        addInstr(0, encodeR(FN_JR, rZero, rZero, rZero, 0));
        // Fill of logical versus arithmetic shifts, zero-extended logic immediates
        newTest(1, "shiftsLui", 32'hF101800F, untouchedData);
        addInstr(1, encodeI(OP_LUI, rZero, rT0, 16'h8001));
        addInstr(1, encodeI(OP_ORI, rT0, rT0, 16'h00F0));
        addInstr(1, encodeR(FN_SRA, rZero, rT0, rT1, 4));
        addInstr(1, encodeR(FN_SRL, rZero, rT0, rT2, 4));
        addInstr(1, encodeR(FN_SLL, rZero, rT0, rT3, 8));
        addInstr(1, encodeR(FN_XOR, rT1, rT2, rV0, 0));
        addInstr(1, encodeR(FN_XOR, rV0, rT3, rV0, 0));
        addInstr(1, encodeI(OP_ANDI, rT1, rT0, 16'hFFFF));
        addInstr(1, encodeI(OP_XORI, rT0, rT0, 16'h8000));
        addInstr(1, encodeR(FN_ADDU, rV0, rT0, rV0, 0));
        addInstr(1, encodeR(FN_JR, rZero, rZero, rZero, 0));
        // Store to 0x300, load back with a negative offset
        newTest(2, "storeLoad", 32'hCAFEBEF1, 32'hCAFEBEF1);
        addInstr(2, encodeI(OP_ORI, rZero, rT0, 16'h0300));
        addInstr(2, encodeI(OP_LUI, rZero, rT1, 16'hCAFE));
        addInstr(2, encodeI(OP_ORI, rT1, rT1, 16'hBEEF));
        addInstr(2, encodeI(OP_SLTIU, rT1, rT2, 16'hFFFF));
        addInstr(2, encodeI(OP_SLTI, rT1, rT3, 16'h0001));
        addInstr(2, encodeR(FN_ADDU, rT1, rT2, rT1, 0));
        addInstr(2, encodeR(FN_ADDU, rT1, rT3, rT1, 0));
        addInstr(2, encodeI(OP_SW, rT0, rT1, 16'h0000));
        addInstr(2, encodeI(OP_ADDIU, rT0, rT0, 16'h0008));
        addInstr(2, encodeI(OP_LW, rT0, rV0, 16'hFFF8));
        addInstr(2, encodeR(FN_JR, rZero, rZero, rZero, 0));
        // Skipped paths add 0x100, 0x200 or 0x400 markers
        newTest(3, "controlFlow", 32'h00000011, untouchedData);
        addInstr(3, encodeI(OP_ORI, rZero, rT0, 16'h0005));
        addInstr(3, encodeI(OP_ORI, rZero, rT1, 16'h0005));
        addInstr(3, encodeI(OP_BEQ, rT0, rT1, 16'h0001));
        addInstr(3, encodeI(OP_ADDIU, rV0, rV0, 16'h0100));
        addInstr(3, encodeI(OP_BEQ, rT0, rZero, 16'h0001));
        addInstr(3, encodeI(OP_ADDIU, rV0, rV0, 16'h0001));
        addInstr(3, encodeI(OP_BNE, rT0, rZero, 16'h0001));
        addInstr(3, encodeI(OP_ADDIU, rV0, rV0, 16'h0200));
        addInstr(3, encodeJ(`RESET_VECTOR + 32'd40));
        addInstr(3, encodeI(OP_ADDIU, rV0, rV0, 16'h0400));
        addInstr(3, encodeI(OP_ADDIU, rV0, rV0, 16'h0010));
        addInstr(3, encodeR(FN_JR, rZero, rZero, rZero, 0));
    endtask

    task automatic runTest(int t);
        int    cycles;
        logic  seenActive;
        string name;
        name = testName[t];
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < 256; i++) begin
            mem0.words[i] = (i < codeLen[t]) ? code[t][i] : fillPattern(i[7:0]);
        end
        repeat (16) @(negedge clk);
        reset = 1'b0;
        // Run until the CPU has started and then halted
        cycles = 0;
        seenActive = 1'b0;
        while (!(seenActive && !active)) begin
            @(negedge clk);
            cycles++;
            if (active) begin
                seenActive = 1'b1;
            end
            if (cycles > 64 * codeLen[t]) begin
                failRun($sformatf("timeout: test %s did not halt within %0d cycles",
                                  name, 64 * codeLen[t]));
            end
        end
        // Halted CPU stays off the bus
        repeat (2) begin
            @(negedge clk);
            checkBit({name, " active"}, 1'b0, active);
            checkBit({name, " read"}, 1'b0, read);
            checkBit({name, " write"}, 1'b0, write);
        end
        checkWord({name, " register_v0"}, expectV0[t], register_v0);
        checkWord({name, " data word 0x300"}, expectMem[t], mem0.words[dataIndex]);
        for (int i = 0; i < 256; i++) begin
            checkWord($sformatf("%s memory word %0d", name, i), expectedWord(t, i),
                      mem0.words[i]);
        end
    endtask

    initial begin
        reset = 1'b1;
        waitEnable = 1'b0;
        buildTable();
        // Second pass repeats the table with random wait states
        for (int pass = 0; pass < 2; pass++) begin
            waitEnable = (pass == 1);
            for (int t = 0; t < numTests; t++) begin
                runTest(t);
            end
        end
        $display("Testbench passed");
        $finish;
    end

endmodule
